//--- bench/iq_model.sv
/*
 * iq_model: software instruction queue that follows the accepted fetch
 * blocks, with the assertions that hold the DUT ports to it
 */
`include "iq_cfg.svh"

module iq_model (
	input  logic								clk,
	input  logic								reset_,
	input  logic								flush_,
	input  queue_pkg::fetch_slot_t [`IQ_WRITE-1:0]	fetch_slots,
	input  queue_pkg::wlane_t					fetch_mask,
	input  logic								fetch_stall,
	input  logic								dec_ready,
	input  isa_pkg::dec_inst_t [`IQ_READ-1:0]	dec_out,
	input  queue_pkg::rlane_t					dec_valid,
	output int									value_errs,
	output int									other_errs
);
	import queue_pkg::*;
	import isa_pkg::*;

	iq_entry_t					q[$];		// oldest first
	logic						exp_stall = 1'b0;
	rlane_t						exp_avail = '0;
	dec_inst_t [`IQ_READ-1:0]	exp_dec = '0;

	// fields taken straight from the word layout
	function automatic dec_inst_t expect_fields(input logic [`IQ_PC-1:0] pc,
			input logic [`IQ_INST-1:0] w);
		dec_inst_t d;
		d = '0;
		d.pc      = pc;
		d.opcode  = w[31:26];
		d.dst     = w[25:21];
		d.src1    = w[20:16];
		d.use_imm = w[31];		// opcode msb picks the immediate form
		if (w[31]) begin
			d.imm = {{16{w[15]}}, w[15:0]};
		end else begin
			d.src2 = w[15:11];
			d.func = w[10:0];
		end
		return d;
	endfunction

	initial begin
		value_errs = 0;
		other_errs = 0;
	end

	// inputs read here still hold their values from before the edge
	always @(posedge clk) begin
		int npop;
		iq_entry_t e;
		if (!reset_ || !flush_) begin
			q.delete();
		end else begin
			if (dec_ready) begin
				npop = (q.size() < `IQ_READ) ? q.size() : `IQ_READ;
				repeat (npop) void'(q.pop_front());
			end
			if (!exp_stall) begin
				for (int i = 0; i < `IQ_WRITE; i++) begin
					if (fetch_mask[i]) begin
						e.pc   = fetch_slots[i].pc;
						e.inst = fetch_slots[i].inst;
						q.push_back(e);
					end
				end
			end
		end
		exp_stall = q.size() > (`IQ_DEPTH - `IQ_WRITE);
		for (int j = 0; j < `IQ_READ; j++) begin
			exp_avail[j] = (j < q.size());
			exp_dec[j]   = (j < q.size()) ? expect_fields(q[j].pc, q[j].inst) : '0;
		end
	end

	stall_level: assert property (@(posedge clk) disable iff (!reset_)
		fetch_stall == exp_stall)
		else begin
			value_errs++;
			$display("error stall_level: expected %b actual %b",
				$sampled(exp_stall), $sampled(fetch_stall));
		end

	lane_valid: assert property (@(posedge clk) disable iff (!reset_)
		dec_valid == (dec_ready ? exp_avail : rlane_t'(0)))
		else begin
			value_errs++;
			$display("error lane_valid: expected %b actual %b",
				$sampled(dec_ready) ? $sampled(exp_avail) : rlane_t'(0), $sampled(dec_valid));
		end

	for (genvar gj = 0; gj < `IQ_READ; gj++) begin : g_lane
		in_order: assert property (@(posedge clk) disable iff (!reset_)
			dec_valid[gj] |-> dec_out[gj].pc == exp_dec[gj].pc
				&& dec_out[gj].opcode == exp_dec[gj].opcode)
			else begin
				value_errs++;
				$display("error in_order lane %0d: expected pc %h op %h actual pc %h op %h", gj,
					$sampled(exp_dec[gj].pc), $sampled(exp_dec[gj].opcode),
					$sampled(dec_out[gj].pc), $sampled(dec_out[gj].opcode));
			end

		fields: assert property (@(posedge clk) disable iff (!reset_)
			dec_valid[gj] |-> dec_out[gj] == exp_dec[gj])
			else begin
				value_errs++;
				$display("error fields lane %0d: expected %h actual %h", gj,
					$sampled(exp_dec[gj]), $sampled(dec_out[gj]));
			end
	end

	held_off: assert property (@(posedge clk) disable iff (!reset_)
		!dec_ready |-> dec_valid == '0)
		else begin
			other_errs++;
			$display("decode lanes were marked valid while dec_ready was low");
		end

	flush_empty: assert property (@(posedge clk) disable iff (!reset_)
		!flush_ |=> (dec_valid == '0 && !fetch_stall))
		else begin
			other_errs++;
			$display("queue still showed entries or stall in the cycle after a flush");
		end

endmodule

//--- bench/iq_tb.sv
/*
 * iq_tb drives seeded random traffic through the instruction queue,
 * checked cycle by cycle against iq_model
 */
`include "iq_cfg.svh"

module iq_tb;
	import queue_pkg::*;
	import isa_pkg::*;

	localparam int PERIOD    = 10;
	localparam int RESET_CYC = 5;
	localparam int RAND_CYC  = 300;
	localparam int FILL_CYC  = 12;
	localparam int DRAIN_CYC = 10;
	localparam int MIX_CYC   = 20;
	localparam int TAIL_CYC  = 40;
	localparam int TOTAL_CYC = RESET_CYC + RAND_CYC + 2 * FILL_CYC + DRAIN_CYC
		+ MIX_CYC + 2 * 2 + TAIL_CYC + 1;

	localparam int MASK_RAND = 0;
	localparam int MASK_FULL = 1;
	localparam int MASK_NONE = 2;

	logic							clk = 1'b0;
	logic							reset_;
	logic							flush_;
	fetch_slot_t [`IQ_WRITE-1:0]	fetch_slots;
	wlane_t							fetch_mask;
	logic							fetch_stall;
	logic							dec_ready;
	dec_inst_t [`IQ_READ-1:0]		dec_out;
	rlane_t							dec_valid;

	integer							seed = 32'hfdef0764;
	logic [`IQ_PC-1:0]				next_pc;
	int								value_errs;
	int								other_errs;

	always #(PERIOD / 2) clk = ~clk;

	iq_top DUT (
		.clk			(clk),
		.reset_			(reset_),
		.flush_			(flush_),
		.fetch_slots	(fetch_slots),
		.fetch_mask		(fetch_mask),
		.fetch_stall	(fetch_stall),
		.dec_ready		(dec_ready),
		.dec_out		(dec_out),
		.dec_valid		(dec_valid)
	);

	iq_model u_model (
		.clk			(clk),
		.reset_			(reset_),
		.flush_			(flush_),
		.fetch_slots	(fetch_slots),
		.fetch_mask		(fetch_mask),
		.fetch_stall	(fetch_stall),
		.dec_ready		(dec_ready),
		.dec_out		(dec_out),
		.dec_valid		(dec_valid),
		.value_errs		(value_errs),
		.other_errs		(other_errs)
	);

	// fresh slots with sequential pcs and a mask of the given kind
	task automatic new_block(input int mask_kind);
		fetch_slot_t [`IQ_WRITE-1:0] s;
		wlane_t m;
		logic [31:0] r;
		for (int i = 0; i < `IQ_WRITE; i++) begin
			s[i].pc   = next_pc + 4 * i;
			s[i].inst = $random(seed);		// either format, either sign
		end
		next_pc = next_pc + 4 * `IQ_WRITE;
		r = $random(seed);
		case (mask_kind)
			MASK_FULL: m = '1;
			MASK_NONE: m = '0;
			default: begin
				case (r[1:0])
					2'd0: m = '0;
					2'd1: m = wlane_t'(1) << r[3:2];		// single slot
					default: m = r[4 +: `IQ_WRITE];
				endcase
			end
		endcase
		fetch_slots <= s;
		fetch_mask  <= m;
	endtask

	// a stalled block is held until it is taken
	task automatic run_cycles(input int n, input int ready_pct, input int mask_kind);
		for (int c = 0; c < n; c++) begin
			@(posedge clk);
			if (!fetch_stall) begin
				new_block(mask_kind);
			end
			dec_ready <= ($unsigned($random(seed)) % 100) < ready_pct;
		end
	endtask

	task automatic pulse_flush();
		@(posedge clk);
		if (!fetch_stall) begin
			new_block(MASK_FULL);
		end
		flush_ <= 1'b0;
		@(posedge clk);
		flush_ <= 1'b1;
		new_block(MASK_FULL);		// first block after the flush
	endtask

	initial begin
		reset_      = 1'b0;
		flush_      = 1'b1;
		fetch_slots = '0;
		fetch_mask  = '0;
		dec_ready   = 1'b0;
		next_pc     = 32'h0000_1000;
		repeat (RESET_CYC) @(posedge clk);
		reset_ <= 1'b1;
		run_cycles(RAND_CYC, 75, MASK_RAND);
		run_cycles(FILL_CYC, 0, MASK_FULL);		// fills up until fetch stalls
		run_cycles(DRAIN_CYC, 100, MASK_NONE);
		run_cycles(MIX_CYC, 30, MASK_RAND);
		pulse_flush();
		run_cycles(FILL_CYC, 0, MASK_FULL);
		pulse_flush();		// flush out of a full queue
		run_cycles(TAIL_CYC, 60, MASK_RAND);
		@(posedge clk);
		@(negedge clk);		// checks of the last edge have reported by now
		$display("errors: %0d value, %0d other", value_errs, other_errs);
		if (value_errs + other_errs == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#((TOTAL_CYC + 100) * PERIOD);
		$display("watchdog: run did not end within %0d cycles", TOTAL_CYC + 100);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- hw/fetch_pack.sv
/*
 * fetch_pack squeezes the valid fetch slots, in slot order,
 * onto write lanes 0..n-1 and writes nothing while busy
 */
`include "iq_cfg.svh"

module fetch_pack (
	input  queue_pkg::fetch_slot_t [`IQ_WRITE-1:0]	fetch_slots,
	input  queue_pkg::wlane_t						fetch_mask,
	input  logic									busy,
	output queue_pkg::wlane_t						we,
	output queue_pkg::iq_entry_t [`IQ_WRITE-1:0]	wd
);
	import queue_pkg::*;

	cnt_t [`IQ_WRITE-1:0]	rank;		// valid slots below this one
	cnt_t					nvalid;

	always_comb begin
		rank[0] = '0;
		for (int i = 1; i < `IQ_WRITE; i++) begin
			rank[i] = rank[i-1] + cnt_t'(fetch_mask[i-1]);
		end
	end

	assign nvalid = count_ones(lane_t'(fetch_mask));

	// each lane picks the valid slot whose rank matches it
	always_comb begin
		wd = '0;
		we = '0;
		for (int k = 0; k < `IQ_WRITE; k++) begin
			for (int i = 0; i < `IQ_WRITE; i++) begin
				if (fetch_mask[i] && rank[i] == cnt_t'(k)) begin
					wd[k].pc   = fetch_slots[i].pc;
					wd[k].inst = fetch_slots[i].inst;
					we[k]      = !busy;		// lane holds a slot
				end
			end
		end
	end

	// an accepted block loses no slot
	always_comb begin
		if (!busy && !$isunknown(fetch_mask)) begin
			lanes_match: assert final (count_ones(lane_t'(we)) == nvalid)
				else $error("fetch_pack: %0d lanes enabled for %0d valid slots",
					count_ones(lane_t'(we)), nvalid);
		end
	end

endmodule

//--- hw/inst_decode.sv
/*
 * inst_decode decodes the oldest queue entries in parallel
 * and drives in-order read enables toward the ring buffer
 */
`include "iq_cfg.svh"

module inst_decode (
	input  queue_pkg::iq_entry_t [`IQ_READ-1:0]	rd,
	input  queue_pkg::rlane_t					rv,
	input  logic								dec_ready,	// downstream can take all lanes
	output queue_pkg::rlane_t					re,
	output isa_pkg::dec_inst_t [`IQ_READ-1:0]	dec_out,
	output queue_pkg::rlane_t					dec_valid
);
	import queue_pkg::*;
	import isa_pkg::*;

	// one entry into operand fields
	function automatic dec_inst_t decode(input iq_entry_t e);
		dec_inst_t d;
		d = '0;
		d.pc      = e.pc;
		d.use_imm = e.inst.rfmt.opcode[OPC_W-1];		// same bits in either view
		if (d.use_imm) begin
			d.opcode = e.inst.ifmt.opcode;
			d.dst    = e.inst.ifmt.dst;
			d.src1   = e.inst.ifmt.src1;
			d.imm    = {{(`IQ_INST - IMM_W){e.inst.ifmt.imm[IMM_W-1]}}, e.inst.ifmt.imm};
		end else begin
			d.opcode = e.inst.rfmt.opcode;
			d.dst    = e.inst.rfmt.dst;
			d.src1   = e.inst.rfmt.src1;
			d.src2   = e.inst.rfmt.src2;
			d.func   = e.inst.rfmt.func;
		end
		return d;
	endfunction

	// rv is already packed from lane 0, so re is too
	assign re        = dec_ready ? rv : '0;
	assign dec_valid = re;		// consumed on the next edge

	for (genvar gj = 0; gj < `IQ_READ; gj++) begin : g_dec
		assign dec_out[gj] = decode(rd[gj]);
	end

	// entries retire in order and leave no gap in rv
	always_comb begin
		if (!$isunknown(rv)) begin
			rv_packed: assert final ((rv & rlane_t'(rv + 1'b1)) == '0)
				else $error("inst_decode: valid lanes not contiguous from lane 0 (rv=%b)", rv);
		end
	end

endmodule

//--- hw/iq_cfg.svh
/*
 * instruction queue configuration
 * queue depth, lane counts and word widths
 */
`ifndef IQ_CFG_SVH
`define IQ_CFG_SVH

// entries in the ring buffer, power of two
`define IQ_DEPTH	16

// fetch slots written per cycle
`define IQ_WRITE	4

// entries read and decoded per cycle
`define IQ_READ		4

`define IQ_INST		32		// instruction word
`define IQ_PC		32		// program counter

`endif

//--- hw/iq_top.sv
/*
 * iq_top: instruction queue, fetch packing into the ring buffer
 * and parallel decode on the way out
 */
`include "iq_cfg.svh"

module iq_top (
	input  logic									clk,
	input  logic									reset_,
	input  logic									flush_,

	// fetch side
	input  queue_pkg::fetch_slot_t [`IQ_WRITE-1:0]	fetch_slots,
	input  queue_pkg::wlane_t						fetch_mask,
	output logic									fetch_stall,	// hold the block

	// decode side
	input  logic									dec_ready,
	output isa_pkg::dec_inst_t [`IQ_READ-1:0]		dec_out,
	output queue_pkg::rlane_t						dec_valid
);
	import queue_pkg::*;

	wlane_t						we;
	iq_entry_t [`IQ_WRITE-1:0]	wd;
	rlane_t						re;
	rlane_t						rv;
	iq_entry_t [`IQ_READ-1:0]	rd;

	fetch_pack u_pack (
		.fetch_slots	(fetch_slots),
		.fetch_mask		(fetch_mask),
		.busy			(fetch_stall),
		.we				(we),
		.wd				(wd)
	);

	ring_buf u_buf (
		.clk			(clk),
		.reset_			(reset_),
		.flush_			(flush_),
		.we				(we),
		.wd				(wd),
		.re				(re),
		.rd				(rd),
		.rv				(rv),
		.busy			(fetch_stall)		// straight out to fetch
	);

	inst_decode u_dec (
		.rd				(rd),
		.rv				(rv),
		.dec_ready		(dec_ready),
		.re				(re),
		.dec_out		(dec_out),
		.dec_valid		(dec_valid)
	);

endmodule

//--- hw/isa_pkg.sv
/*
 * isa_pkg: instruction word formats and the decoded instruction,
 * as seen by the instruction queue and its decode stage
 */
`include "iq_cfg.svh"

package isa_pkg;

	localparam int OPC_W  = 6;
	localparam int REG_W  = 5;
	localparam int FUNC_W = 11;
	localparam int IMM_W  = 16;

	typedef logic [OPC_W-1:0] opcode_t;
	typedef logic [REG_W-1:0] reg_idx_t;

	// register-register form
	typedef struct packed {
		opcode_t			opcode;
		reg_idx_t			dst;
		reg_idx_t			src1;
		reg_idx_t			src2;
		logic [FUNC_W-1:0]	func;
	} reg_fmt_t;

	// register-immediate form
	typedef struct packed {
		opcode_t			opcode;
		reg_idx_t			dst;
		reg_idx_t			src1;
		logic [IMM_W-1:0]	imm;
	} imm_fmt_t;

	// one word, two readings; opcode msb set selects ifmt
	typedef union packed {
		reg_fmt_t	rfmt;
		imm_fmt_t	ifmt;
	} inst_u;

	typedef struct packed {
		logic [`IQ_PC-1:0]		pc;
		opcode_t				opcode;
		reg_idx_t				dst;
		reg_idx_t				src1;
		reg_idx_t				src2;		// zero in immediate form
		logic					use_imm;
		logic [FUNC_W-1:0]		func;		// zero in immediate form
		logic [`IQ_INST-1:0]	imm;		// sign extended, zero in register form
	} dec_inst_t;

endpackage

//--- hw/queue_pkg.sv
/*
 * queue_pkg: fetch slot and queue entry layouts, lane vectors
 * and the enable bit counter shared by the queue blocks
 */
`include "iq_cfg.svh"

package queue_pkg;

	localparam int LANE_MAX = (`IQ_WRITE > `IQ_READ) ? `IQ_WRITE : `IQ_READ;
	localparam int CNT_W    = $clog2(LANE_MAX + 1);
	localparam int ADDR_W   = $clog2(`IQ_DEPTH);

	typedef logic [`IQ_WRITE-1:0] wlane_t;		// one bit per write lane
	typedef logic [`IQ_READ-1:0]  rlane_t;		// one bit per read lane
	typedef logic [LANE_MAX-1:0]  lane_t;		// widest of the two
	typedef logic [CNT_W-1:0]     cnt_t;
	typedef logic [ADDR_W-1:0]    qaddr_t;		// queue index, wraps naturally

	// as delivered by fetch
	typedef struct packed {
		logic [`IQ_PC-1:0]	pc;
		isa_pkg::inst_u		inst;
	} fetch_slot_t;

	// as stored in the ring buffer
	typedef struct packed {
		logic [`IQ_PC-1:0]	pc;
		isa_pkg::inst_u		inst;
	} iq_entry_t;

	// number of set bits, narrower vectors are zero extended by the caller
	function automatic cnt_t count_ones(input lane_t vec);
		cnt_t n;
		n = '0;
		for (int i = 0; i < LANE_MAX; i++) begin
			n = n + cnt_t'(vec[i]);
		end
		return n;
	endfunction

endpackage

//--- hw/ring_buf.sv
/*
 * ring_buf: multi-port circular buffer for the instruction queue
 * up to IQ_WRITE pushes and IQ_READ pops per cycle, in order
 */
`include "iq_cfg.svh"

module ring_buf (
	input  logic									clk,
	input  logic									reset_,
	input  logic									flush_,		// drops every entry

	input  queue_pkg::wlane_t						we,
	input  queue_pkg::iq_entry_t [`IQ_WRITE-1:0]	wd,

	input  queue_pkg::rlane_t						re,
	output queue_pkg::iq_entry_t [`IQ_READ-1:0]		rd,
	output queue_pkg::rlane_t						rv,

	output logic									busy		// a full block may not fit
);
	import queue_pkg::*;

	iq_entry_t [`IQ_DEPTH-1:0]	data;
	logic [`IQ_DEPTH-1:0]		valid;
	qaddr_t						head;		// next slot to write
	qaddr_t						tail;		// oldest entry

	qaddr_t [`IQ_WRITE-1:0]		wr_addr;
	qaddr_t [`IQ_READ-1:0]		rd_addr;
	wlane_t						wr_taken;	// write target already holds data
	qaddr_t						check_ptr;
	cnt_t						wnum;
	cnt_t						rnum;
	qaddr_t						next_head;
	qaddr_t						next_tail;

	// lane addresses, depth is a power of two so the sum wraps by itself
	for (genvar gi = 0; gi < `IQ_WRITE; gi++) begin : g_wr
		assign wr_addr[gi]  = head + qaddr_t'(gi);
		assign wr_taken[gi] = valid[wr_addr[gi]];
	end

	for (genvar gj = 0; gj < `IQ_READ; gj++) begin : g_rd
		assign rd_addr[gj] = tail + qaddr_t'(gj);
		assign rd[gj]      = data[rd_addr[gj]];
		assign rv[gj]      = valid[rd_addr[gj]];
	end

	// last slot a full block would need
	assign check_ptr = head + qaddr_t'(`IQ_WRITE - 1);
	assign busy      = valid[check_ptr];

	assign wnum      = count_ones(lane_t'(we));
	assign rnum      = count_ones(lane_t'(re));
	assign next_head = head + qaddr_t'(wnum);
	assign next_tail = tail + qaddr_t'(rnum);

	always_ff @(posedge clk or negedge reset_) begin
		if (!reset_) begin
			head  <= '0;
			tail  <= '0;
			valid <= '0;
		end else if (!flush_) begin
			head  <= '0;
			tail  <= '0;
			valid <= '0;
		end else begin
			head <= next_head;
			tail <= next_tail;
			for (int i = 0; i < `IQ_WRITE; i++) begin
				if (we[i]) begin
					valid[wr_addr[i]] <= 1'b1;
				end
			end
			// pops never hit a slot being pushed this cycle
			for (int j = 0; j < `IQ_READ; j++) begin
				if (re[j]) begin
					valid[rd_addr[j]] <= 1'b0;
				end
			end
		end
	end

	// entry storage
	always_ff @(posedge clk) begin
		if (flush_) begin
			for (int i = 0; i < `IQ_WRITE; i++) begin
				if (we[i]) begin
					data[wr_addr[i]] <= wd[i];
				end
			end
		end
	end

	// pack stage must hand over lanes 0..n-1 only
	we_packed: assert property (@(posedge clk) disable iff (!reset_)
		(we & wlane_t'(we + 1'b1)) == '0)
		else $error("ring_buf: write enables not contiguous from lane 0 (we=%b)", we);

	// busy must have held back anything that would overrun the tail
	no_overwrite: assert property (@(posedge clk) disable iff (!reset_)
		(we & wr_taken) == '0)
		else $error("ring_buf: write to occupied entry (we=%b taken=%b)", we, wr_taken);

	// decode may only consume what is there
	read_valid: assert property (@(posedge clk) disable iff (!reset_)
		(re & ~rv) == '0)
		else $error("ring_buf: read of empty entry (re=%b rv=%b)", re, rv);

endmodule

//--- list.f
+incdir+hw
hw/isa_pkg.sv
hw/queue_pkg.sv
hw/ring_buf.sv
hw/fetch_pack.sv
hw/inst_decode.sv
hw/iq_top.sv
bench/iq_model.sv
bench/iq_tb.sv
